//--- build.f
+incdir+verilog
verilog/board_pkg.sv
verilog/audio_pkg.sv
verilog/hs_sender.sv
verilog/mic_i2s_receiver.sv
verilog/key_debouncer.sv
verilog/panel_mixer.sv
verilog/board_top.sv
test/tb_clock.sv
test/board_top_asserts.sv
test/tb_board_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module tb_board_top \
    -Mdir obj_dir -o sim_board_top

./obj_dir/sim_board_top | tee "$LOG"

if grep -q "Simulation failed" "$LOG"; then
    echo "Testbench reported failure, see $LOG"
    exit 1
fi

if ! grep -q "Simulation completed successfully" "$LOG"; then
    echo "Testbench ended without a result, see $LOG"
    exit 1
fi

//--- test/tb_board_top.sv
`default_nettype none

`include "board_params.svh"

module tb_board_top;

    import board_pkg::*;
    import audio_pkg::*;

    localparam int RESET_CYCLES   = 16;
    localparam int FRAME_CYCLES   = 2 * W_SLOT * 2 * `MIC_SCK_HALF;   // clk cycles per frame
    localparam int SETTLE_LIMIT   = 4 * `DEBOUNCE_CYCLES + 32;
    localparam int HOLD_CYCLES    = 2 * `DEBOUNCE_CYCLES;
    localparam int MIN_LED_CHECKS = 16;

    // Hex glyphs, abcdefgh with 1 lit
    localparam seg_t GLYPHS [16] = '{8'hfc, 8'h60, 8'hda, 8'hf2, 8'h66, 8'hb6, 8'hbe, 8'he0,
                                     8'hfe, 8'hf6, 8'hee, 8'h3e, 8'h9c, 8'h7a, 8'h9e, 8'h8e};

    logic        clk;
    logic        rst;
    key_t        key_n;
    logic        sd = 1'b0;
    logic        sck;
    logic        ws;
    logic        lr;
    led_t        led;
    seg_t        abcdefgh;
    digit_t      digit;

    int          errors       = 0;
    int          led_checks   = 0;
    int          key_checks   = 0;
    logic [15:0] mic_lfsr     = 16'd12;          // Separate streams per process
    logic [15:0] key_lfsr     = 16'd12;
    logic        sck_q        = 1'b0;
    logic        ws_q         = 1'b0;
    int          slot_pos     = 0;               // sck periods since ws fell
    logic [23:0] mic_word     = '0;
    logic        word_valid   = 1'b0;
    int          sample_count = 0;
    logic [31:0] mic_junk;

    tb_clock u_clock (.clk(clk));

    board_top u_board_top
    (
        .clk      (clk),
        .rst      (rst),
        .key_n    (key_n),
        .sck      (sck),
        .ws       (ws),
        .lr       (lr),
        .sd       (sd),
        .led      (led),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    // ----------------------------------------------------------
    // Random bits and reference model
    // ----------------------------------------------------------

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};   // x16+x14+x13+x11+1
    endfunction

    task automatic draw_bits(inout logic [15:0] state, input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            state = lfsr_step(state);
            value = {value[30:0], state[0]};     // One step per bit
        end
    endtask

    function automatic led_t expected_bar(input logic [23:0] raw);
        int value;
        int top;
        int level;
        value = {{8{raw[23]}}, raw};
        if (value < 0)
            value = -value;
        if (value > 8388607)
            value = 8388607;                     // Most negative saturates
        top = -1;
        for (int b = 0; b < W_SAMPLE; b++)
            if (value[b])
                top = b;
        level = top - 15;
        if (level < 0)
            level = 0;
        if (level > 8)
            level = 8;
        return led_t'((1 << level) - 1);
    endfunction

    function automatic seg_t expected_seg(input key_t pressed);
        for (int i = 0; i < W_KEY; i++)
            if (pressed[i])
                return GLYPHS[i];                // Lowest index wins
        return '0;
    endfunction

    function automatic digit_t expected_digit(input key_t pressed);
        return (|pressed) ? digit_t'(1) : '0;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            errors++;
            $display("CHECK FAILED %s: expected %h got %h", name, exp, got);
        end
    endtask

    // ----------------------------------------------------------
    // I2S microphone model
    // ----------------------------------------------------------

    task automatic next_mic_word(output logic [23:0] value);
        logic [31:0] bits;
        logic [31:0] shift;
        case (sample_count)
        0:       value = 24'h000000;
        1:       value = 24'h7fffff;             // Most positive
        2:       value = 24'h800000;             // Most negative
        default:
        begin
            draw_bits(mic_lfsr, W_SAMPLE, bits);
            draw_bits(mic_lfsr, 4, shift);
            value = $signed(bits[23:0]) >>> shift[3:0];   // Spread over all levels
        end
        endcase
        sample_count++;
    endtask

    always @(posedge clk)
    begin
        if (!rst && sck_q && !sck)               // sck fell on the last edge
        begin
            if (ws_q && !ws)                     // New left slot
            begin
                if (word_valid)
                begin
                    led_checks++;
                    check_value("led", led, expected_bar(mic_word));
                end
                next_mic_word(mic_word);
                word_valid = 1'b1;
                slot_pos   = 0;
            end
            else
                slot_pos = slot_pos + 1;

            if (word_valid && !ws && slot_pos >= 1 && slot_pos <= W_SAMPLE)
                sd <= mic_word[W_SAMPLE - slot_pos];   // MSB at slot bit 1
            else
            begin
                draw_bits(mic_lfsr, 1, mic_junk);
                sd <= mic_junk[0];               // Filler the receiver ignores
            end
        end
        sck_q = sck;
        ws_q  = ws;
    end

    // ----------------------------------------------------------
    // Key driver and display checks
    // ----------------------------------------------------------

    function automatic logic display_matches(input key_t pressed);
        return (abcdefgh === expected_seg(pressed)) && (digit === expected_digit(pressed));
    endfunction

    task automatic check_display(input key_t pressed);
        key_checks++;
        check_value("abcdefgh", abcdefgh, expected_seg(pressed));
        check_value("digit", digit, expected_digit(pressed));
    endtask

    task automatic hold_check(input key_t pressed, input int cycles);
        repeat (cycles)
        begin
            @(posedge clk);
            check_display(pressed);
        end
    endtask

    task automatic wait_display(input key_t pressed);
        int waited;
        waited = 0;
        while (!display_matches(pressed) && waited < SETTLE_LIMIT)
        begin
            @(posedge clk);
            waited++;
        end
        if (!display_matches(pressed))
        begin
            errors++;
            $display("Key display did not settle for keys %h, abcdefgh %h digit %h",
                     pressed, abcdefgh, digit);
        end
    endtask

    task automatic press_and_check(input key_t pressed);
        key_n <= ~pressed;                       // Active low pins
        wait_display(pressed);
        hold_check(pressed, HOLD_CYCLES);
    endtask

    task automatic run_glitches();
        logic [31:0] bits;
        key_t        base;
        int          idx;
        int          len;
        draw_bits(key_lfsr, W_KEY, bits);
        base = bits[W_KEY - 1:0];
        press_and_check(base);
        for (int g = 0; g < 8; g++)
        begin
            draw_bits(key_lfsr, 2, bits);
            idx = int'(bits[1:0]) % W_KEY;
            draw_bits(key_lfsr, 3, bits);
            len = int'(bits[2:0]) % (`DEBOUNCE_CYCLES - 1) + 1;   // Always short of a flip
            key_n <= ~(base ^ key_t'(1 << idx));
            hold_check(base, len);
            key_n <= ~base;
            hold_check(base, HOLD_CYCLES);
        end
    endtask

    task automatic run_busy_window();
        logic [31:0] bits;
        key_t        last;
        int          gap;
        for (int r = 0; r < W_KEY; r++)
        begin
            press_and_check(key_t'(1 << r));
            key_n <= '1;                         // Release all
            draw_bits(key_lfsr, 2, bits);
            gap = int'(bits[1:0]) % 3 + 1;       // Second flip lands on a busy sender
            repeat (gap) @(posedge clk);
            last = key_t'(1 << ((r + 2) % W_KEY));
            press_and_check(last);
        end
        press_and_check('0);
    endtask

    initial
    begin
        logic [31:0] bits;
        int          waited;
        rst   = 1'b1;
        key_n = '1;
        repeat (RESET_CYCLES) @(posedge clk);

        check_value("led", led, '0);             // Reset values
        check_value("abcdefgh", abcdefgh, '0);
        check_value("digit", digit, '0);
        check_value("sck", sck, '0);
        check_value("ws", ws, '0);
        check_value("lr", lr, '0);
        rst <= 1'b0;

        for (int k = 0; k < W_KEY; k++)
            press_and_check(key_t'(1 << k));
        for (int s = 0; s < 8; s++)
        begin
            draw_bits(key_lfsr, W_KEY, bits);
            press_and_check(bits[W_KEY - 1:0]);  // Several keys at once
        end
        run_glitches();
        run_busy_window();

        waited = 0;
        while (led_checks < MIN_LED_CHECKS && waited < (MIN_LED_CHECKS + 2) * FRAME_CYCLES)
        begin
            @(posedge clk);
            waited++;
        end
        if (led_checks < MIN_LED_CHECKS)
        begin
            errors++;
            $display("Only %0d LED updates were checked before the timeout", led_checks);
        end

        $display("Errors %0d, LED checks %0d, key checks %0d", errors, led_checks, key_checks);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/board_top_asserts.sv
`default_nettype none

module board_top_asserts
(
    input logic clk,
    input logic rst,
    input logic req,
    input logic ack
);

    // ----------------------------------------------------------
    // Four-phase handshake rules
    // ----------------------------------------------------------

    assert property (@(posedge clk) disable iff (rst) req && !ack |=> req)
        else $error("hs_sender req dropped before ack");

    assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> req)
        else $error("hs_sender ack rose without req");

    assert property (@(posedge clk) disable iff (rst) $rose(req) |-> !ack)
        else $error("hs_sender req rose while ack high");

    assert property (@(posedge clk) disable iff (rst) $fell(ack) |-> !req)
        else $error("hs_sender ack fell with req still high");

endmodule

bind hs_sender board_top_asserts u_handshake_asserts
(
    .clk  (clk),
    .rst  (rst),
    .req  (req),
    .ack  (ack)
);

`default_nettype wire

//--- test/tb_clock.sv
`default_nettype none

module tb_clock
#(
    parameter int PERIOD = 4                     // Time units per clk period
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever
            #(PERIOD / 2) clk = ~clk;            // Free running, 50 percent duty
    end

endmodule

`default_nettype wire

//--- verilog/board_top.sv
`default_nettype none

module board_top
(
    input  logic              clk,
    input  logic              rst,
    input  board_pkg::key_t   key_n,             // Push keys, active low
    output logic              sck,               // Mic bit clock
    output logic              ws,                // Mic word select
    output logic              lr,                // Mic channel select
    input  logic              sd,                // Mic serial data
    output board_pkg::led_t   led,
    output board_pkg::seg_t   abcdefgh,
    output board_pkg::digit_t digit
);

    import board_pkg::*;
    import audio_pkg::*;

    // ----------------------------------------------------------
    // Channels into the mixer
    // ----------------------------------------------------------

    logic    mic_req;
    logic    mic_ack;
    sample_t mic_sample;
    logic    key_req;
    logic    key_ack;
    key_t    key_state;

    assign lr = 1'b0;                            // Mic answers in the left slot

    mic_i2s_receiver u_mic
    (
        .clk    (clk),
        .rst    (rst),
        .sck    (sck),
        .ws     (ws),
        .sd     (sd),
        .req    (mic_req),
        .sample (mic_sample),
        .ack    (mic_ack)
    );

    key_debouncer u_keys
    (
        .clk   (clk),
        .rst   (rst),
        .key_n (key_n),
        .req   (key_req),
        .state (key_state),
        .ack   (key_ack)
    );

    panel_mixer u_mixer
    (
        .clk        (clk),
        .rst        (rst),
        .mic_req    (mic_req),
        .mic_sample (mic_sample),
        .mic_ack    (mic_ack),
        .key_req    (key_req),
        .key_state  (key_state),
        .key_ack    (key_ack),
        .led        (led),
        .abcdefgh   (abcdefgh),
        .digit      (digit)
    );

endmodule

`default_nettype wire

//--- verilog/panel_mixer.sv
`default_nettype none

module panel_mixer
(
    input  logic               clk,
    input  logic               rst,
    input  logic               mic_req,
    input  audio_pkg::sample_t mic_sample,
    output logic               mic_ack,
    input  logic               key_req,
    input  board_pkg::key_t    key_state,
    output logic               key_ack,
    output board_pkg::led_t    led,
    output board_pkg::seg_t    abcdefgh,
    output board_pkg::digit_t  digit
);

    import board_pkg::*;
    import audio_pkg::*;

    localparam int LEVEL_BASE = 15;              // Bit 16 lights the first LED
    localparam int W_LEVEL    = $clog2(W_LED + 1);

    logic                 mic_req_q;
    logic                 key_req_q;
    logic                 mic_take;              // ack rising this cycle
    logic                 key_take;
    mag_t                 magnitude;
    logic [W_LEVEL - 1:0] level;
    led_t                 bar;
    logic                 key_any;
    logic [3:0]           key_idx;               // Lowest pressed key
    seg_t                 glyph;

    function automatic seg_t hex_glyph(input logic [3:0] value);
        case (value)                             // abcdefgh
        4'h0:    return 8'b1111_1100;
        4'h1:    return 8'b0110_0000;
        4'h2:    return 8'b1101_1010;
        4'h3:    return 8'b1111_0010;
        4'h4:    return 8'b0110_0110;
        4'h5:    return 8'b1011_0110;
        4'h6:    return 8'b1011_1110;
        4'h7:    return 8'b1110_0000;
        4'h8:    return 8'b1111_1110;
        4'h9:    return 8'b1111_0110;
        4'ha:    return 8'b1110_1110;
        4'hb:    return 8'b0011_1110;
        4'hc:    return 8'b1001_1100;
        4'hd:    return 8'b0111_1010;
        4'he:    return 8'b1001_1110;
        default: return 8'b1000_1110;            // F
        endcase
    endfunction

    // ----------------------------------------------------------
    // Level bar
    // ----------------------------------------------------------

    always_comb
    begin
        if (!mic_sample[W_SAMPLE - 1])
            magnitude = mic_sample[W_MAG - 1:0];
        else if (mic_sample[W_MAG - 1:0] == '0)
            magnitude = '1;                      // Most negative saturates
        else
            magnitude = mag_t'(-mic_sample);

        level = '0;
        for (int i = LEVEL_BASE + 1; i < W_MAG; i++)
            if (magnitude[i])
                level = W_LEVEL'(i - LEVEL_BASE);   // Highest set bit wins
        if (level > W_LEVEL'(W_LED))
            level = W_LEVEL'(W_LED);

        for (int j = 0; j < W_LED; j++)
            bar[j] = (j < level);                // Thermometer from LED 0
    end

    // ----------------------------------------------------------
    // Key glyph
    // ----------------------------------------------------------

    always_comb
    begin
        key_any = |key_state;
        key_idx = '0;
        for (int i = W_KEY - 1; i >= 0; i--)
            if (key_state[i])
                key_idx = 4'(i);                 // Lowest index last
        glyph = key_any ? hex_glyph(key_idx) : '0;
    end

    // ----------------------------------------------------------
    // Handshake acceptors and panel registers
    // ----------------------------------------------------------

    assign mic_take = mic_req_q & ~mic_ack;
    assign key_take = key_req_q & ~key_ack;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            mic_req_q <= 1'b0;
            key_req_q <= 1'b0;
            mic_ack   <= 1'b0;
            key_ack   <= 1'b0;
            led       <= '0;
            abcdefgh  <= '0;
            digit     <= '0;
        end
        else
        begin
            mic_req_q <= mic_req;                // req seen one cycle later
            key_req_q <= key_req;

            if (mic_take)
            begin
                mic_ack <= 1'b1;
                led     <= bar;                  // Payload taken with ack
            end
            else if (!mic_req_q)
                mic_ack <= 1'b0;

            if (key_take)
            begin
                key_ack  <= 1'b1;
                abcdefgh <= glyph;
                digit    <= key_any ? digit_t'(1) : '0;   // Rightmost position only
            end
            else if (!key_req_q)
                key_ack <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/key_debouncer.sv
`default_nettype none

`include "board_params.svh"

module key_debouncer
(
    input  logic            clk,
    input  logic            rst,
    input  board_pkg::key_t key_n,               // Active low pins
    output logic            req,
    output board_pkg::key_t state,
    input  logic            ack
);

    import board_pkg::*;

    localparam int W_CNT = $clog2(`DEBOUNCE_CYCLES + 1);

    key_t               key_meta;                // First sync stage
    key_t               key_sync;
    key_t               pressed;
    key_t               stable;                  // Debounced vector
    key_t               flip;
    logic [W_CNT - 1:0] cnt [W_KEY];             // Differing cycles per key
    logic               pending;                 // Change not yet offered
    logic               busy;
    logic               load;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            key_meta <= '1;                      // Released
            key_sync <= '1;
        end
        else
        begin
            key_meta <= key_n;
            key_sync <= key_meta;
        end
    end

    assign pressed = ~key_sync;

    // A bit flips on its DEBOUNCE_CYCLES-th differing cycle
    always_comb
    begin
        for (int i = 0; i < W_KEY; i++)
            flip[i] = (pressed[i] != stable[i]) && (cnt[i] == W_CNT'(`DEBOUNCE_CYCLES - 1));
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            stable  <= '0;
            pending <= 1'b0;
            for (int i = 0; i < W_KEY; i++)
                cnt[i] <= '0;
        end
        else
        begin
            for (int i = 0; i < W_KEY; i++)
            begin
                if (pressed[i] == stable[i] || flip[i])
                    cnt[i] <= '0;                // Run broken or completed
                else
                    cnt[i] <= cnt[i] + W_CNT'(1);
            end

            stable  <= stable ^ flip;
            pending <= (pending & ~load) | (|flip);   // Re-armed by a late change
        end
    end

    assign load = pending & ~busy;               // Current vector, never a stale one

    hs_sender
    #(
        .payload_t (key_t)
    )
    u_sender
    (
        .clk     (clk),
        .rst     (rst),
        .load    (load),
        .data    (stable),
        .busy    (busy),
        .req     (req),
        .payload (state),
        .ack     (ack)
    );

endmodule

`default_nettype wire

//--- verilog/mic_i2s_receiver.sv
`default_nettype none

`include "board_params.svh"

module mic_i2s_receiver
(
    input  logic               clk,
    input  logic               rst,
    output logic               sck,
    output logic               ws,
    input  logic               sd,
    output logic               req,
    output audio_pkg::sample_t sample,
    input  logic               ack
);

    import audio_pkg::*;

    localparam int FRAME_BITS = `MIC_FRAME_SLOTS * W_SLOT;   // sck periods per frame
    localparam int W_BIT      = $clog2(FRAME_BITS);
    localparam int W_DIV      = $clog2(`MIC_SCK_HALF) + 1;

    logic [W_DIV - 1:0] div_cnt;                 // clk cycles within an sck half
    logic [W_BIT - 1:0] bit_cnt;                 // sck period within the frame
    logic [W_BIT - 1:0] bit_next;
    logic               sck_edge;
    logic               sck_rise;
    logic               sck_fall;
    logic               in_word;                 // Slot bits 1 to W_SAMPLE
    sample_t            shift_reg;
    logic               word_done;
    logic               busy;
    logic               load;

    // ----------------------------------------------------------
    // sck and ws generation
    // ----------------------------------------------------------

    assign sck_edge = (div_cnt == W_DIV'(`MIC_SCK_HALF - 1));
    assign sck_rise = sck_edge & ~sck;
    assign sck_fall = sck_edge &  sck;

    assign bit_next = (bit_cnt == W_BIT'(FRAME_BITS - 1)) ? '0 : bit_cnt + W_BIT'(1);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
            bit_cnt <= '0;
            ws      <= 1'b0;                     // Left slot first
        end
        else
        begin
            if (sck_edge)
            begin
                div_cnt <= '0;
                sck     <= ~sck;
            end
            else
                div_cnt <= div_cnt + W_DIV'(1);

            if (sck_fall)
            begin
                bit_cnt <= bit_next;
                ws      <= (bit_next >= W_BIT'(W_SLOT));   // ws moves on falling sck
            end
        end
    end

    // ----------------------------------------------------------
    // Left word capture
    // ----------------------------------------------------------

    // MSB arrives one sck period after ws falls
    assign in_word = (bit_cnt != '0) && (bit_cnt <= W_BIT'(W_SAMPLE));

    always_ff @(posedge clk)
    begin
        if (sck_rise && in_word)
            shift_reg <= {shift_reg[W_SAMPLE - 2:0], sd};   // MSB first
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            word_done <= 1'b0;
        else
            word_done <= sck_rise && (bit_cnt == W_BIT'(W_SAMPLE));   // Last bit taken
    end

    // Newest sample lost if the channel is still open
    assign load = word_done & ~busy;

    hs_sender
    #(
        .payload_t (sample_t)
    )
    u_sender
    (
        .clk     (clk),
        .rst     (rst),
        .load    (load),
        .data    (shift_reg),
        .busy    (busy),
        .req     (req),
        .payload (sample),
        .ack     (ack)
    );

endmodule

`default_nettype wire

//--- verilog/hs_sender.sv
`default_nettype none

module hs_sender
#(
    parameter type payload_t = logic [7:0]
)
(
    input  logic     clk,
    input  logic     rst,
    input  logic     load,                       // Producer offers data
    input  payload_t data,
    output logic     busy,                       // Load refused while high
    output logic     req,
    output payload_t payload,
    input  logic     ack
);

    typedef enum logic [1:0]
    {
        IDLE,                                    // Ready for a load
        REQUEST,                                 // req high, waiting for ack
        RELEASE                                  // req low, waiting for ack low
    } state_t;

    state_t state;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state <= IDLE;
            req   <= 1'b0;
        end
        else
        begin
            case (state)
            IDLE:
                if (load)
                begin
                    state <= REQUEST;
                    req   <= 1'b1;               // Payload latched on the same edge
                end
            REQUEST:
                if (ack)
                begin
                    state <= RELEASE;
                    req   <= 1'b0;
                end
            RELEASE:
                if (!ack)
                    state <= IDLE;               // Four phases closed
            default:
                state <= IDLE;
            endcase
        end
    end

    // Held stable for the whole request phase
    always_ff @(posedge clk)
    begin
        if (state == IDLE && load)
            payload <= data;
    end

    assign busy = (state != IDLE);

endmodule

`default_nettype wire

//--- verilog/audio_pkg.sv
`default_nettype none

package audio_pkg;

    // ----------------------------------------------------------
    // I2S word layout
    // ----------------------------------------------------------

    parameter int W_SAMPLE = 24;                 // Mic word, MSB first
    parameter int W_SLOT   = 32;                 // sck periods per ws half
    parameter int W_MAG    = W_SAMPLE - 1;       // Magnitude without sign

    // ----------------------------------------------------------
    // Stream types
    // ----------------------------------------------------------

    // Two's complement sample as shifted in from sd
    typedef logic signed [W_SAMPLE - 1:0] sample_t;

    // Absolute value, saturated for the most negative sample
    typedef logic        [W_MAG    - 1:0] mag_t;

endpackage

`default_nettype wire

//--- verilog/board_pkg.sv
`default_nettype none

package board_pkg;

    // ----------------------------------------------------------
    // Panel widths
    // ----------------------------------------------------------

    parameter int W_KEY   = 4;                   // Push keys on the board
    parameter int W_LED   = 8;                   // Level bar length
    parameter int W_SEG   = 8;                   // abcdefgh
    parameter int W_DIGIT = 4;                   // Digit enables

    // ----------------------------------------------------------
    // Panel vectors
    // ----------------------------------------------------------

    typedef logic [W_KEY   - 1:0] key_t;         // 1 is pressed after inversion
    typedef logic [W_LED   - 1:0] led_t;         // 1 is lit
    typedef logic [W_SEG   - 1:0] seg_t;         // Bit 7 is a, bit 0 is h
    typedef logic [W_DIGIT - 1:0] digit_t;       // Bit 0 is the rightmost position

endpackage

`default_nettype wire

//--- verilog/board_params.svh
`ifndef BOARD_PARAMS_SVH
`define BOARD_PARAMS_SVH

// ----------------------------------------------------------
// Microphone clocking
// ----------------------------------------------------------

`define MIC_SCK_HALF     2   // clk cycles per sck half period

`define MIC_FRAME_SLOTS  2   // Left plus right ws slot per frame

// ----------------------------------------------------------
// Key filtering
// ----------------------------------------------------------

`define DEBOUNCE_CYCLES  8   // Consecutive differing cycles per flip

`endif
